/* Bender.yml */
package:
  name: fft16

sources:
  - include_dirs:
      - design
    files:
      - design/fft_pkg.sv
      - design/sdf_stage.sv
      - design/reorder_buffer.sv
      - design/fft16_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/fft_tb.sv

/* bench/fft_tb.sv */
`include "fft_defines.svh"

module fft_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fft_pkg::*;

    localparam int SEED           = 32'ha2f8_fa57;
    localparam int NUM_FRAMES     = 12;
    localparam int RESET_CYCLES   = 10;
    localparam int FRAME_CYCLES   = 300;    // input, pipeline, drain under credit stalls
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 400;
    localparam int IW             = `IN_WIDTH;
    localparam int IMPULSE        = 0;
    localparam int CONSTANT       = 1;
    localparam int ALTERNATE      = 2;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    in_sample_t  din;
    logic        frame_credit;
    logic        credit;
    logic        out_valid;
    out_sample_t dout;

    int   frame_kind [NUM_FRAMES+1];
    int   frame_val  [NUM_FRAMES+1];
    int   frames_sent;
    int   frames_done;
    int   out_cnt;                          // outputs seen in the current frame
    int   dut_credits;                      // credits the DUT holds
    int   cycles;
    logic first_sent;
    int   data_errors;
    int   credit_errors;
    int   protocol_errors;
    int   exp_re_now;
    int   exp_im_now;

    always #20 clk = ~clk;

    fft16_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid_i     (in_valid),
        .din_i          (din),
        .frame_credit_o (frame_credit),
        .credit_i       (credit),
        .out_valid_o    (out_valid),
        .dout_o         (dout)
    );

    //////////////////////////////////////////////////////////////////////
    // frame contents and expected spectra
    //////////////////////////////////////////////////////////////////////

    function automatic int sample_re(int kind, int val, int n);
        case (kind)
            IMPULSE:  return (n == 0) ? val : 0;
            CONSTANT: return val;
            default:  return (n % 2 == 1) ? -val : val;
        endcase
    endfunction

    function automatic int sample_im(int kind, int val);
        return (kind == CONSTANT) ? val : 0;
    endfunction

    function automatic int expect_re(int kind, int val, int bin);
        case (kind)
            IMPULSE:  return val;                                  // flat spectrum
            CONSTANT: return (bin == 0) ? `FFT_POINTS * val : 0;
            default:  return (bin == `FFT_POINTS / 2) ? `FFT_POINTS * val : 0;
        endcase
    endfunction

    function automatic int expect_im(int kind, int val, int bin);
        return (kind == CONSTANT && bin == 0) ? `FFT_POINTS * val : 0;
    endfunction

    always_comb begin
        exp_re_now = expect_re(frame_kind[frames_done], frame_val[frames_done], out_cnt);
        exp_im_now = expect_im(frame_kind[frames_done], frame_val[frames_done], out_cnt);
    end

    //////////////////////////////////////////////////////////////////////
    // output tracking
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cnt     <= 0;
            frames_done <= 0;
            dut_credits <= 0;
        end else begin
            if (out_valid) begin
                out_cnt <= out_cnt + 1;
            end
            if (frame_credit) begin
                out_cnt     <= 0;
                frames_done <= frames_done + 1;
            end
            dut_credits <= dut_credits + int'(credit) - int'(out_valid);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles, %0d of %0d frames done",
                     TIMEOUT_CYCLES, frames_done, NUM_FRAMES);
            report_counts();
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) (!rst_n || !first_sent) |-> (!out_valid && !frame_credit))
        else begin
            protocol_errors++;
            $display("ERROR at %0t: output activity before the first frame", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (int'(dout.re) == exp_re_now && int'(dout.im) == exp_im_now))
        else begin
            data_errors++;
            $display("ERROR at %0t: frame %0d bin %0d got (%0d, %0d), expected (%0d, %0d)",
                     $time, $sampled(frames_done), $sampled(out_cnt), $sampled(dout.re),
                     $sampled(dout.im), $sampled(exp_re_now), $sampled(exp_im_now));
        end

    // the credit taken in the cycle of the read cannot pay for that read
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (dut_credits - int'($past(credit))) > 0)
        else begin
            credit_errors++;
            $display("ERROR at %0t: out_valid without an output credit", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> out_cnt < `FFT_POINTS)
        else begin
            credit_errors++;
            $display("ERROR at %0t: more than %0d outputs in one frame", $time, `FFT_POINTS);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        frame_credit |-> (out_cnt == `FFT_POINTS && frames_done < frames_sent))
        else begin
            credit_errors++;
            $display("ERROR at %0t: frame credit after %0d outputs", $time, $sampled(out_cnt));
        end

    assert property (@(posedge clk) disable iff (!rst_n) frame_credit |=> !frame_credit)
        else begin
            credit_errors++;
            $display("ERROR at %0t: frame credit held longer than one cycle", $time);
        end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic wait_drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic report_counts();
        $display("errors: data %0d, credit %0d, protocol %0d",
                 data_errors, credit_errors, protocol_errors);
    endtask

    task automatic send_frame(input int kind, input int val);
        while (frames_sent > frames_done) begin
            wait_drive_slot();                  // no frame credit yet
        end
        frame_kind[frames_sent] = kind;
        frame_val[frames_sent]  = val;
        frames_sent++;
        first_sent = 1'b1;
        for (int n = 0; n < `FFT_POINTS; n++) begin
            in_valid = 1'b1;
            din.re   = IW'(sample_re(kind, val, n));
            din.im   = IW'(sample_im(kind, val));
            wait_drive_slot();
        end
        in_valid = 1'b0;
        din      = '0;
    endtask

    // consumer returning credits with random busy spells
    task automatic feed_credits();
        int stall;
        stall = 0;
        forever begin
            wait_drive_slot();
            credit = 1'b0;
            if (stall > 0) begin
                stall--;
            end else if ($urandom_range(15) == 0) begin
                stall = $urandom_range(24, 4);
            end else if (dut_credits < `OUT_CREDIT_MAX && $urandom_range(3) != 0) begin
                credit = 1'b1;
            end
        end
    endtask

    initial begin
        int kind;
        int val;
        void'($urandom(SEED));
        clk             = 1'b0;
        rst_n           = 1'b1;
        in_valid        = 1'b0;
        din             = '0;
        credit          = 1'b0;
        first_sent      = 1'b0;
        frames_sent     = 0;
        cycles          = 0;
        data_errors     = 0;
        credit_errors   = 0;
        protocol_errors = 0;
        #1 rst_n = 1'b0;                        // clean falling edge for the async reset
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
        fork
            feed_credits();
        join_none
        // the three frame kinds in order before a random mix
        for (int f = 0; f < NUM_FRAMES; f++) begin
            kind = (f < 3) ? f : int'($urandom_range(2));
            if (kind == IMPULSE) begin
                val = int'($urandom_range(4094)) - 2047;
            end else begin
                val = int'($urandom_range(254)) - 127;
            end
            send_frame(kind, val);
        end
        while (frames_done < NUM_FRAMES) begin
            wait_drive_slot();
        end
        repeat (8) wait_drive_slot();           // catch stray outputs
        if (out_cnt != 0) begin
            protocol_errors++;
            $display("ERROR at %0t: %0d outputs after the last frame", $time, out_cnt);
        end
        report_counts();
        if (data_errors + credit_errors + protocol_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* design/fft16_top.sv */
`include "fft_defines.svh"

module fft16_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid_i,
    input  fft_pkg::in_sample_t  din_i,
    output logic                 frame_credit_o,
    input  logic                 credit_i,
    output logic                 out_valid_o,
    output fft_pkg::out_sample_t dout_o
);
    import fft_pkg::*;

    localparam int EXT_BITS = `DP_WIDTH - `IN_WIDTH - `FRAC_BITS;

    logic                 in_valid_q;
    cplx_t                in_data_q;
    logic [`FFT_STAGES:0] stage_valid;
    cplx_t                stage_data [`FFT_STAGES+1];

    //////////////////////////////////////////////////////////////////////
    // input register with sign extension into Q8
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        in_data_q.re <= {{EXT_BITS{din_i.re[`IN_WIDTH-1]}}, din_i.re, {`FRAC_BITS{1'b0}}};
        in_data_q.im <= {{EXT_BITS{din_i.im[`IN_WIDTH-1]}}, din_i.im, {`FRAC_BITS{1'b0}}};
    end

    assign stage_valid[0] = in_valid_q;
    assign stage_data[0]  = in_data_q;

    //////////////////////////////////////////////////////////////////////
    // delay-feedback stages with delays 8 4 2 1
    //////////////////////////////////////////////////////////////////////

    for (genvar s = 0; s < `FFT_STAGES; s++) begin : g_stage
        sdf_stage #(
            .DELAY (`FFT_POINTS >> (s + 1))
        ) u_stage (
            .clk     (clk),
            .rst_n   (rst_n),
            .valid_i (stage_valid[s]),
            .data_i  (stage_data[s]),
            .valid_o (stage_valid[s+1]),
            .data_o  (stage_data[s+1])
        );
    end

    reorder_buffer u_reorder (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (stage_valid[`FFT_STAGES]),
        .data_i         (stage_data[`FFT_STAGES]),
        .credit_i       (credit_i),
        .out_valid_o    (out_valid_o),
        .dout_o         (dout_o),
        .frame_credit_o (frame_credit_o)
    );

    // a frame is one unbroken burst of FFT_POINTS samples
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_valid_i) |-> in_valid_i [*`FFT_POINTS] ##1 !in_valid_i)
        else $error("fft16_top: input frame not %0d consecutive samples", `FFT_POINTS);

endmodule

/* design/fft_defines.svh */
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// transform size
//////////////////////////////////////////////////////////////////////

`define FFT_POINTS 16      // points per frame
`define FFT_STAGES 4       // log2 of FFT_POINTS

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

`define IN_WIDTH  12       // input component
`define DP_WIDTH  24       // datapath component
`define FRAC_BITS 8        // Q8 datapath and twiddles
`define OUT_WIDTH 16       // bits 23..8 of the datapath

//////////////////////////////////////////////////////////////////////
// flow control
//////////////////////////////////////////////////////////////////////

// output credits the consumer may have outstanding
`define OUT_CREDIT_MAX 4

`endif

/* design/fft_pkg.sv */
`include "fft_defines.svh"

package fft_pkg;

    //////////////////////////////////////////////////////////////////////
    // complex samples
    //////////////////////////////////////////////////////////////////////

    // raw input from the source
    typedef struct packed {
        logic signed [`IN_WIDTH-1:0] re;
        logic signed [`IN_WIDTH-1:0] im;
    } in_sample_t;

    // internal datapath with FRAC_BITS fraction bits
    typedef struct packed {
        logic signed [`DP_WIDTH-1:0] re;
        logic signed [`DP_WIDTH-1:0] im;
    } cplx_t;

    // result as seen by the consumer
    typedef struct packed {
        logic signed [`OUT_WIDTH-1:0] re;
        logic signed [`OUT_WIDTH-1:0] im;
    } out_sample_t;

    //////////////////////////////////////////////////////////////////////
    // control states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        FILL    = 1'b0,       // first half loads the delay line
        COMPUTE = 1'b1        // second half runs the butterfly
    } stage_phase_e;

    typedef enum logic {
        COLLECT = 1'b0,       // write bit-reversed
        DRAIN   = 1'b1        // read natural order
    } reorder_state_e;

endpackage

/* design/reorder_buffer.sv */
`include "fft_defines.svh"

module reorder_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_i,
    input  fft_pkg::cplx_t       data_i,
    input  logic                 credit_i,
    output logic                 out_valid_o,
    output fft_pkg::out_sample_t dout_o,
    output logic                 frame_credit_o
);
    import fft_pkg::*;

    localparam int AW  = $clog2(`FFT_POINTS);
    localparam int CCW = $clog2(`OUT_CREDIT_MAX + 1);

    reorder_state_e state;
    out_sample_t    mem [`FFT_POINTS];
    logic [AW-1:0]  wr_cnt;
    logic [AW-1:0]  wr_addr;
    logic [AW-1:0]  rd_cnt;
    logic [CCW-1:0] credit_cnt;
    logic           wr_en;
    logic           spend;
    logic           drain_done;

    //////////////////////////////////////////////////////////////////////
    // collect side
    //////////////////////////////////////////////////////////////////////

    assign wr_en = valid_i && (state == COLLECT);

    // stages emit bins in bit-reversed order
    always_comb begin
        for (int b = 0; b < AW; b++) begin
            wr_addr[b] = wr_cnt[AW-1-b];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // drain side
    //////////////////////////////////////////////////////////////////////

    assign spend = (state == DRAIN) && (credit_cnt != '0) && !drain_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= COLLECT;
            wr_cnt         <= '0;
            rd_cnt         <= '0;
            drain_done     <= 1'b0;
            out_valid_o    <= 1'b0;
            frame_credit_o <= 1'b0;
        end else begin
            out_valid_o    <= spend;
            drain_done     <= spend && (rd_cnt == AW'(`FFT_POINTS - 1));
            frame_credit_o <= drain_done;     // one pulse after the last result

            if (wr_en) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (spend) begin
                rd_cnt <= rd_cnt + 1'b1;
            end

            case (state)
                COLLECT: begin
                    if (wr_en && wr_cnt == AW'(`FFT_POINTS - 1)) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (drain_done) begin
                        state <= COLLECT;
                    end
                end
                default: state <= COLLECT;
            endcase
        end
    end

    // saturating output credit count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= '0;
        end else begin
            case ({credit_i, spend})
                2'b10: begin
                    if (credit_cnt != CCW'(`OUT_CREDIT_MAX)) begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;  // none or one in and one out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr].re <= data_i.re[`DP_WIDTH-1:`FRAC_BITS];
            mem[wr_addr].im <= data_i.im[`DP_WIDTH-1:`FRAC_BITS];
        end
        if (spend) begin
            dout_o <= mem[rd_cnt];
        end
    end

    // the pipeline must be idle while a frame is still draining
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == DRAIN) |-> !valid_i)
        else $error("reorder_buffer: valid_i during DRAIN");

    // a credit arriving on a full count would push it past the limit
    assert property (@(posedge clk) disable iff (!rst_n)
        (credit_i && !spend) |-> (credit_cnt != CCW'(`OUT_CREDIT_MAX)))
        else $error("reorder_buffer: credit count above OUT_CREDIT_MAX");

endmodule

/* design/sdf_stage.sv */
`include "fft_defines.svh"

module sdf_stage #(
    parameter int DELAY = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           valid_i,
    input  fft_pkg::cplx_t data_i,
    output logic           valid_o,
    output fft_pkg::cplx_t data_o
);
    import fft_pkg::*;

    localparam int CW       = $clog2(2 * DELAY);
    localparam int PW       = (DELAY > 1) ? $clog2(DELAY) : 1;
    localparam int TW_N     = `FFT_POINTS / 2;
    localparam int TIW      = $clog2(TW_N);
    localparam int STEP     = `FFT_POINTS / (2 * DELAY);
    localparam int TW_WIDTH = `FRAC_BITS + 2;
    localparam int PROD_W   = `DP_WIDTH + TW_WIDTH + 1;

    // W = cos - j sin in Q8
    localparam logic signed [TW_WIDTH-1:0] TW_COS [TW_N] = '{
        10'sd256, 10'sd237, 10'sd181, 10'sd98,
        10'sd0, -10'sd98, -10'sd181, -10'sd237
    };
    localparam logic signed [TW_WIDTH-1:0] TW_SIN [TW_N] = '{
        10'sd0, -10'sd98, -10'sd181, -10'sd237,
        -10'sd256, -10'sd237, -10'sd181, -10'sd98
    };

    logic [CW-1:0]              cnt;
    logic [PW-1:0]              pos;
    logic [TIW-1:0]             tw_idx;
    stage_phase_e               phase;
    logic                       pending;
    logic                       run;
    logic                       pos_last;

    cplx_t                      dly [DELAY];
    cplx_t                      dly_out;
    cplx_t                      sum;
    cplx_t                      diff;
    cplx_t                      diff_tw;
    logic signed [TW_WIDTH-1:0] w_re;
    logic signed [TW_WIDTH-1:0] w_im;
    logic signed [PROD_W-1:0]   prod_re;
    logic signed [PROD_W-1:0]   prod_im;

    //////////////////////////////////////////////////////////////////////
    // phase counter
    //////////////////////////////////////////////////////////////////////

    assign phase    = stage_phase_e'(cnt[CW-1]);
    assign pos      = cnt[PW-1:0] & PW'(DELAY - 1);
    assign pos_last = (pos == PW'(DELAY - 1));
    assign run      = valid_i | pending;      // new data or diffs still in the line
    assign tw_idx   = TIW'(pos * STEP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            pending <= 1'b0;
        end else if (run) begin
            if (phase == FILL && pos_last && !valid_i) begin
                cnt <= '0;                    // park at fill start after the flush
            end else begin
                cnt <= cnt + 1'b1;
            end

            if (phase == COMPUTE && pos_last) begin
                pending <= 1'b1;
            end else if (phase == FILL && pos_last) begin
                pending <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // butterfly and twiddle multiply
    //////////////////////////////////////////////////////////////////////

    assign dly_out = dly[DELAY-1];
    assign w_re    = TW_COS[tw_idx];
    assign w_im    = TW_SIN[tw_idx];

    always_comb begin
        sum.re  = dly_out.re + data_i.re;
        sum.im  = dly_out.im + data_i.im;
        diff.re = dly_out.re - data_i.re;
        diff.im = dly_out.im - data_i.im;

        prod_re = diff.re * w_re - diff.im * w_im;
        prod_im = diff.re * w_im + diff.im * w_re;

        // truncation drops the twiddle fraction
        diff_tw.re = prod_re[`FRAC_BITS +: `DP_WIDTH];
        diff_tw.im = prod_im[`FRAC_BITS +: `DP_WIDTH];
    end

    // feedback delay line
    always_ff @(posedge clk) begin
        if (run) begin
            dly[0] <= (phase == FILL) ? data_i : diff_tw;
            for (int i = 1; i < DELAY; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= (phase == COMPUTE && valid_i) || (phase == FILL && pending);
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            data_o <= (phase == FILL) ? dly_out : sum;  // old diffs in fill and sums in compute
        end
    end

    // upstream runs are 2*DELAY long and phase aligned
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(valid_i) |-> (pos == '0))
        else $error("sdf_stage: valid_i rose in the middle of a phase");

endmodule

/* files.f */
+incdir+design
design/fft_pkg.sv
design/sdf_stage.sv
design/reorder_buffer.sv
design/fft16_top.sv
bench/fft_tb.sv
